// File: common/rename_pkg.sv
// sizes assume 8 ROB entries and 32 registers; tag 0 is reserved as "no producer"
package rename_pkg;

    // architectural register file
    localparam int NUM_ARCH_REGS = 32;
    localparam int REG_IDX_W     = 5;

    // reorder buffer, tags run 1..ROB_DEPTH
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = 4;

    // register index as it arrives from decode
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // producer tag, zero when the value lives in the register file
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // one map table slot
    // t_plus set means the result is done and parked in the ROB
    typedef struct packed {
        rob_tag_t rob_tag;
        logic     t_plus;
    } map_entry_t;

endpackage

// File: common/rename_ifs.sv
// complete_vec is indexed by tag 1..ROB_DEPTH; new_tag reads 0 while the ROB is full
`timescale 1ns/10ps

// allocation, completion and squash traffic around the ROB tracker
interface rob_alloc_if import rename_pkg::*; ();

    logic               alloc;
    reg_idx_t           alloc_dest;
    rob_tag_t           new_tag;
    logic               full;
    logic [ROB_DEPTH:1] complete_vec;
    logic               squash_valid;
    rob_tag_t           squash_tag;

    // dispatch side
    modport resolver (
        output alloc,
        output alloc_dest,
        input  new_tag,
        input  full,
        input  squash_valid
    );

    modport rob (
        input  alloc,
        input  alloc_dest,
        output new_tag,
        output full,
        output complete_vec,
        input  squash_valid,
        input  squash_tag
    );

    // map table needs the tail tag for snapshots and completions for restore
    modport map (
        input complete_vec,
        input new_tag,
        input squash_valid,
        input squash_tag
    );

endinterface

// source lookups and destination write into the map table
interface map_lookup_if import rename_pkg::*; ();

    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    map_entry_t rs1_entry;
    map_entry_t rs2_entry;
    logic       write;
    reg_idx_t   write_idx;

    modport resolver (
        output rs1_idx,
        output rs2_idx,
        input  rs1_entry,
        input  rs2_entry,
        output write,
        output write_idx
    );

    modport map (
        input  rs1_idx,
        input  rs2_idx,
        output rs1_entry,
        output rs2_entry,
        input  write,
        input  write_idx
    );

endinterface

// File: rename/map_table.sv
// lookups are combinational; a squash must not coincide with a write, and checkpoints are valid only for allocated tags
`timescale 1ns/10ps

module map_table import rename_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    map_lookup_if.map    lookup,
    rob_alloc_if.map     rob,
    input  logic         cdb_valid,
    input  rob_tag_t     cdb_tag,
    input  logic         retire_valid,
    input  rob_tag_t     retire_tag
);

    // live mapping and its value for the next edge
    map_entry_t live      [NUM_ARCH_REGS];
    map_entry_t live_next [NUM_ARCH_REGS];

    // one full snapshot per tag, taken when that tag is allocated
    map_entry_t ckpt [1:ROB_DEPTH][NUM_ARCH_REGS];

    // apply this edge's retire clearing and CDB marking to one entry
    function automatic map_entry_t age_entry(
        input map_entry_t e,
        input logic       cv,
        input rob_tag_t   ct,
        input logic       rv,
        input rob_tag_t   rt
    );
        map_entry_t result;
        result = e;
        if (rv && e.rob_tag == rt) begin
            // last writer left the ROB, value now in the register file
            result = '0;
        end else if (cv && e.rob_tag != '0 && e.rob_tag == ct) begin
            result.t_plus = 1'b1;
        end
        return result;
    endfunction

    // snapshot entry brought back on a squash
    function automatic map_entry_t restore_entry(
        input map_entry_t         e,
        input logic [ROB_DEPTH:1] done,
        input logic               cv,
        input rob_tag_t           ct,
        input logic               rv,
        input rob_tag_t           rt
    );
        map_entry_t result;
        result = age_entry(e, cv, ct, rv, rt);
        if (result.rob_tag != '0) begin
            // t_plus comes from the ROB's completion bits, not the snapshot
            result.t_plus = done[result.rob_tag] | (cv && ct == result.rob_tag);
        end
        return result;
    endfunction

    always_comb begin
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            if (rob.squash_valid) begin
                live_next[r] = restore_entry(ckpt[rob.squash_tag][r], rob.complete_vec,
                                             cdb_valid, cdb_tag, retire_valid, retire_tag);
            end else begin
                live_next[r] = age_entry(live[r], cdb_valid, cdb_tag, retire_valid, retire_tag);
            end
        end
        // new producer overrides everything else for its register
        if (lookup.write && !rob.squash_valid) begin
            live_next[lookup.write_idx] = '{rob_tag: rob.new_tag, t_plus: 1'b0};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                live[r] <= '0;
            end
        end else begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                live[r] <= live_next[r];
            end
        end
    end

    // snapshots follow the same marking and clearing as the live table
    always_ff @(posedge clock) begin
        for (int t = 1; t <= ROB_DEPTH; t++) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                ckpt[t][r] <= age_entry(ckpt[t][r], cdb_valid, cdb_tag,
                                        retire_valid, retire_tag);
            end
        end
        // the tail slot is free, so it is rewritten every cycle;
        // on the dispatch edge it captures the mapping including the new dest
        if (rob.new_tag != '0) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                ckpt[rob.new_tag][r] <= live_next[r];
            end
        end
    end

    // source reads
    assign lookup.rs1_entry = live[lookup.rs1_idx];
    assign lookup.rs2_entry = live[lookup.rs2_idx];

endmodule

// File: rename/rob_tracker.sv
// tracks tags only, no result data; squash_tag must be an allocated entry and cdb_tag a live one
`timescale 1ns/10ps

module rob_tracker import rename_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    rob_alloc_if.rob   alloc,
    input  logic       cdb_valid,
    input  rob_tag_t   cdb_tag,
    output logic       retire_valid,
    output rob_tag_t   retire_tag,
    output reg_idx_t   retire_dest
);

    // oldest entry and next free slot
    rob_tag_t             head;
    rob_tag_t             tail;
    logic [ROB_TAG_W-1:0] count;

    reg_idx_t             dest [1:ROB_DEPTH];
    logic [ROB_DEPTH:1]   complete;

    logic                 full;
    // entries that survive a squash, head through squash_tag
    logic [ROB_TAG_W-1:0] kept;

    // tags wrap from ROB_DEPTH back to 1
    function automatic rob_tag_t next_tag(input rob_tag_t t);
        return (t == rob_tag_t'(ROB_DEPTH)) ? rob_tag_t'(1) : t + rob_tag_t'(1);
    endfunction

    // how far an entry sits behind the head, 0 for the head itself
    function automatic logic [ROB_TAG_W-1:0] age_of(input rob_tag_t t, input rob_tag_t h);
        return (t >= h) ? t - h : t + rob_tag_t'(ROB_DEPTH) - h;
    endfunction

    assign full = (count == ROB_TAG_W'(ROB_DEPTH));
    assign kept = age_of(alloc.squash_tag, head) + ROB_TAG_W'(1);

    // no tag is offered while full, which also protects the head checkpoint
    assign alloc.new_tag      = full ? '0 : tail;
    assign alloc.full         = full;
    assign alloc.complete_vec = complete;

    // retire whenever the head is done, never stalled
    assign retire_valid = (count != '0) && complete[head];
    assign retire_tag   = head;
    assign retire_dest  = dest[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head     <= rob_tag_t'(1);
            tail     <= rob_tag_t'(1);
            count    <= '0;
            complete <= '0;
        end else begin
            if (alloc.alloc) begin
                complete[tail] <= 1'b0;
                tail           <= next_tag(tail);
            end
            if (cdb_valid && cdb_tag != '0) begin
                complete[cdb_tag] <= 1'b1;
            end
            if (retire_valid) begin
                complete[head] <= 1'b0;
                head           <= next_tag(head);
            end
            count <= count + ROB_TAG_W'(alloc.alloc) - ROB_TAG_W'(retire_valid);

            // squash drops everything younger than squash_tag
            if (alloc.squash_valid) begin
                tail  <= next_tag(alloc.squash_tag);
                count <= kept - ROB_TAG_W'(retire_valid);
                for (int t = 1; t <= ROB_DEPTH; t++) begin
                    if (age_of(rob_tag_t'(t), head) >= kept) begin
                        complete[t] <= 1'b0;
                    end
                end
            end
        end
    end

    // destination per entry, payload only
    always_ff @(posedge clock) begin
        if (alloc.alloc) begin
            dest[tail] <= alloc.alloc_dest;
        end
    end

endmodule

// File: hw/operand_resolver.sv
// purely combinational; source and dest outputs are meaningful only while dispatch_valid is high
`timescale 1ns/10ps

module operand_resolver import rename_pkg::*; (
    input  logic              dispatch_valid,
    input  logic              has_dest,
    input  logic              rs1_valid,
    input  logic              rs2_valid,
    input  reg_idx_t          dest_idx,
    input  reg_idx_t          rs1_idx,
    input  reg_idx_t          rs2_idx,
    input  logic              cdb_valid,
    input  rob_tag_t          cdb_tag,
    map_lookup_if.resolver    lookup,
    rob_alloc_if.resolver     alloc,
    output logic              dispatch_ready,
    output rob_tag_t          dest_tag,
    output rob_tag_t          rs1_tag,
    output rob_tag_t          rs2_tag,
    output logic              rs1_ready,
    output logic              rs2_ready
);

    logic fire;

    // unused sources read as tag 0
    function automatic rob_tag_t src_tag(input logic valid, input map_entry_t e);
        return valid ? e.rob_tag : '0;
    endfunction

    // ready from the register file, from the ROB, or off the CDB this cycle
    function automatic logic src_ready(
        input logic       valid,
        input map_entry_t e,
        input logic       cv,
        input rob_tag_t   ct
    );
        return !valid || e.rob_tag == '0 || e.t_plus || (cv && ct == e.rob_tag);
    endfunction

    // a squash in flight always beats dispatch
    assign dispatch_ready = !alloc.full && !alloc.squash_valid;
    assign fire           = dispatch_valid && dispatch_ready;

    assign alloc.alloc      = fire;
    assign alloc.alloc_dest = has_dest ? dest_idx : '0;
    assign dest_tag         = alloc.new_tag;

    // x0 is hardwired, never renamed
    assign lookup.write     = fire && has_dest && dest_idx != '0;
    assign lookup.write_idx = dest_idx;
    assign lookup.rs1_idx   = rs1_idx;
    assign lookup.rs2_idx   = rs2_idx;

    assign rs1_tag   = src_tag(rs1_valid, lookup.rs1_entry);
    assign rs2_tag   = src_tag(rs2_valid, lookup.rs2_entry);
    assign rs1_ready = src_ready(rs1_valid, lookup.rs1_entry, cdb_valid, cdb_tag);
    assign rs2_ready = src_ready(rs2_valid, lookup.rs2_entry, cdb_valid, cdb_tag);

endmodule

// File: hw/rename_core.sv
// rename only, no values; a held request must stay stable until dispatch_ready, and squash_tag must be in flight
`timescale 1ns/10ps

module rename_core import rename_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  logic     has_dest,
    input  reg_idx_t dest_idx,
    input  logic     rs1_valid,
    input  reg_idx_t rs1_idx,
    input  logic     rs2_valid,
    input  reg_idx_t rs2_idx,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  logic     squash_valid,
    input  rob_tag_t squash_tag,
    output logic     dispatch_ready,
    output rob_tag_t dest_tag,
    output rob_tag_t rs1_tag,
    output logic     rs1_ready,
    output rob_tag_t rs2_tag,
    output logic     rs2_ready,
    output logic     retire_valid,
    output rob_tag_t retire_tag,
    output reg_idx_t retire_dest
);

    rob_alloc_if  alloc_bus ();
    map_lookup_if lookup_bus ();

    // branch squash enters on the ROB bus
    assign alloc_bus.squash_valid = squash_valid;
    assign alloc_bus.squash_tag   = squash_tag;

    operand_resolver resolver (
        .dispatch_valid (dispatch_valid),
        .has_dest       (has_dest),
        .rs1_valid      (rs1_valid),
        .rs2_valid      (rs2_valid),
        .dest_idx       (dest_idx),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .lookup         (lookup_bus.resolver),
        .alloc          (alloc_bus.resolver),
        .dispatch_ready (dispatch_ready),
        .dest_tag       (dest_tag),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag),
        .rs1_ready      (rs1_ready),
        .rs2_ready      (rs2_ready)
    );

    map_table map (
        .clock        (clock),
        .reset        (reset),
        .lookup       (lookup_bus.map),
        .rob          (alloc_bus.map),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .retire_valid (retire_valid),
        .retire_tag   (retire_tag)
    );

    rob_tracker rob (
        .clock        (clock),
        .reset        (reset),
        .alloc        (alloc_bus.rob),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .retire_valid (retire_valid),
        .retire_tag   (retire_tag),
        .retire_dest  (retire_dest)
    );

endmodule

// File: sim/rename_model.svh
// included inside the testbench module after its signals; lfsr_state must be seeded before first use
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

logic [31:0]        lfsr_state;
rob_tag_t           m_map  [NUM_ARCH_REGS];
rob_tag_t           m_ckpt [1:ROB_DEPTH][NUM_ARCH_REGS];
reg_idx_t           m_dest [1:ROB_DEPTH];
logic [ROB_DEPTH:1] m_done;
rob_tag_t           m_head;
rob_tag_t           m_tail;
int                 m_count;
logic               last_fire;

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
    return out;
endfunction

function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v = (v << 1) | 32'(lfsr_bit());
    end
    return v;
endfunction

// folds any count from 1 upward onto tags 1..ROB_DEPTH
function automatic rob_tag_t wrap_tag(input int t);
    return rob_tag_t'((t - 1) % ROB_DEPTH + 1);
endfunction

// register file, finished producer, or CDB bypass in this cycle
function automatic logic expect_ready(input logic valid, input rob_tag_t t);
    return !valid || t == '0 || m_done[t] || (cdb_valid && cdb_tag == t);
endfunction

task automatic model_reset();
    for (int r = 0; r < NUM_ARCH_REGS; r++) begin
        m_map[r] = '0;
    end
    m_done    = '0;
    m_head    = rob_tag_t'(1);
    m_tail    = rob_tag_t'(1);
    m_count   = 0;
    last_fire = 1'b0;
endtask

// one clock edge: retire first, then cdb, then squash or dispatch
task automatic model_step();
    rob_tag_t old_head;
    int       old_count;
    int       kept;
    logic     ret;
    old_head  = m_head;
    old_count = m_count;
    ret       = m_count > 0 && m_done[m_head];
    last_fire = dispatch_valid && m_count < ROB_DEPTH && !squash_valid;
    if (ret) begin
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            if (m_map[r] == old_head) begin
                m_map[r] = '0;
            end
            for (int t = 1; t <= ROB_DEPTH; t++) begin
                if (m_ckpt[t][r] == old_head) begin
                    m_ckpt[t][r] = '0;
                end
            end
        end
        m_done[old_head] = 1'b0;
        m_head  = wrap_tag(old_head + 1);
        m_count = m_count - 1;
    end
    if (cdb_valid && cdb_tag != '0) begin
        m_done[cdb_tag] = 1'b1;
    end
    if (squash_valid) begin
        // entries from the old head up to and including squash_tag survive
        kept = (int'(squash_tag) - int'(old_head) + ROB_DEPTH) % ROB_DEPTH + 1;
        for (int a = kept; a < old_count; a++) begin
            m_done[wrap_tag(old_head + a)] = 1'b0;
        end
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            m_map[r] = m_ckpt[squash_tag][r];
        end
        m_tail  = wrap_tag(squash_tag + 1);
        m_count = kept - int'(ret);
    end else if (last_fire) begin
        m_done[m_tail] = 1'b0;
        m_dest[m_tail] = has_dest ? dest_idx : '0;
        if (has_dest && dest_idx != '0) begin
            m_map[dest_idx] = m_tail;
        end
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            m_ckpt[m_tail][r] = m_map[r];
        end
        m_tail  = wrap_tag(m_tail + 1);
        m_count = m_count + 1;
    end
endtask

`endif

// File: sim/rename_core_tb.sv
// random dispatch, cdb and squash traffic checked against a reference model; needs --timing
`timescale 1ns/10ps

module rename_core_tb import rename_pkg::*; ();

    localparam int          NUM_TESTS      = 6;
    localparam int          TEST_CYCLES    = 160;
    localparam int          TIMEOUT_FACTOR = 4;
    localparam int          WAIT_LIMIT     = 128;
    localparam logic [31:0] LFSR_SEED      = 32'hc6ce;

    logic     clock;
    logic     reset;
    logic     dispatch_valid;
    logic     has_dest;
    reg_idx_t dest_idx;
    logic     rs1_valid;
    reg_idx_t rs1_idx;
    logic     rs2_valid;
    reg_idx_t rs2_idx;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    logic     squash_valid;
    rob_tag_t squash_tag;
    logic     dispatch_ready;
    rob_tag_t dest_tag;
    rob_tag_t rs1_tag;
    logic     rs1_ready;
    rob_tag_t rs2_tag;
    logic     rs2_ready;
    logic     retire_valid;
    rob_tag_t retire_tag;
    reg_idx_t retire_dest;

    string test_name;
    int    checks;
    int    errors;
    int    tests_run;
    int    test_checks;
    int    test_errors;

    `include "rename_model.svh"

    rename_core uut (.*);

    always #2 clock = ~clock;

    // model follows the same edges as the DUT
    always @(posedge clock) begin
        if (reset) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            check_outputs();
        end
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * TIMEOUT_FACTOR * 4);
        $display("watchdog expired while running %s", test_name);
        $display("Test failures found");
        $finish;
    end

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic check_outputs();
        rob_tag_t e1;
        rob_tag_t e2;
        logic     rv;
        logic     room;
        e1   = rs1_valid ? m_map[rs1_idx] : '0;
        e2   = rs2_valid ? m_map[rs2_idx] : '0;
        rv   = m_count > 0 && m_done[m_head];
        room = m_count < ROB_DEPTH;
        compare("dispatch_ready", room && !squash_valid, dispatch_ready);
        compare("dest_tag", room ? m_tail : '0, dest_tag);
        compare("rs1_tag", e1, rs1_tag);
        compare("rs1_ready", expect_ready(rs1_valid, e1), rs1_ready);
        compare("rs2_tag", e2, rs2_tag);
        compare("rs2_ready", expect_ready(rs2_valid, e2), rs2_ready);
        compare("retire_valid", rv, retire_valid);
        if (rv) begin
            compare("retire_tag", m_head, retire_tag);
            compare("retire_dest", m_dest[m_head], retire_dest);
        end
    endtask

    // odds are out of 4; a request that did not fire is held unchanged
    task automatic drive_cycle(input int disp_odds, input int cdb_odds, input bit squash_on);
        int off;
        @(posedge clock);
        #0.5;
        if (!dispatch_valid || last_fire) begin
            dispatch_valid = rand_bits(2) < disp_odds;
            has_dest       = rand_bits(3) != 0;
            dest_idx       = reg_idx_t'(rand_bits(REG_IDX_W));
            rs1_valid      = rand_bits(2) != 0;
            rs1_idx        = reg_idx_t'(rand_bits(REG_IDX_W));
            rs2_valid      = rand_bits(2) != 0;
            rs2_idx        = reg_idx_t'(rand_bits(REG_IDX_W));
        end
        // only in-flight, unfinished tags go on the CDB
        off          = int'(rand_bits(3));
        cdb_tag      = wrap_tag(m_head + off);
        cdb_valid    = rand_bits(2) < cdb_odds && off < m_count && !m_done[cdb_tag];
        squash_valid = squash_on && m_count > 0;
        squash_tag   = wrap_tag(m_head + (m_count > 0 ? off % m_count : 0));
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while ((m_count > 0 || dispatch_valid) && guard < WAIT_LIMIT) begin
            drive_cycle(0, 4, 0);
            guard++;
        end
        if (m_count > 0 || dispatch_valid) begin
            errors++;
            $display("%s: ROB still busy after %0d cycles", test_name, WAIT_LIMIT);
        end
    endtask

    task automatic wait_ready();
        int guard;
        guard = 0;
        @(negedge clock);
        while (!dispatch_ready && guard < WAIT_LIMIT) begin
            drive_cycle(4, 4, 0);
            @(negedge clock);
            guard++;
        end
        if (!dispatch_ready) begin
            errors++;
            $display("%s: dispatch_ready stayed low for %0d cycles", test_name, WAIT_LIMIT);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("%-13s %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    initial begin
        lfsr_state     = LFSR_SEED;
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        has_dest       = 1'b0;
        dest_idx       = '0;
        rs1_valid      = 1'b0;
        rs1_idx        = '0;
        rs2_valid      = 1'b0;
        rs2_idx        = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        squash_valid   = 1'b0;
        squash_tag     = '0;
        checks         = 0;
        errors         = 0;
        tests_run      = 0;
        test_name      = "reset";
        repeat (10) @(posedge clock);
        #0.5;
        reset = 1'b0;

        start_test("reset");
        repeat (4) drive_cycle(0, 0, 0);
        finish_test();

        start_test("rename");
        repeat (7) drive_cycle(4, 0, 0);
        drain();
        finish_test();

        start_test("ready");
        repeat (60) drive_cycle(2, 2, 0);
        drain();
        finish_test();

        start_test("retire");
        repeat (6) drive_cycle(4, 0, 0);
        drain();
        finish_test();

        // fill past the ROB depth, then hold until a retirement frees a slot
        start_test("backpressure");
        repeat (ROB_DEPTH + 3) drive_cycle(4, 0, 0);
        wait_ready();
        drain();
        finish_test();

        start_test("squash");
        repeat (5) begin
            repeat (6) drive_cycle(3, 1, 0);
            drive_cycle(0, 0, 1);
            repeat (4) drive_cycle(3, 1, 0);
        end
        drain();
        finish_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: rename_core.f
+incdir+sim
common/rename_pkg.sv
common/rename_ifs.sv
rename/map_table.sv
rename/rob_tracker.sv
hw/operand_resolver.sv
hw/rename_core.sv
sim/rename_core_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := rename_core_tb
FILELIST  := rename_core.f
BUILD_DIR := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)
